// ==== Bender.yml ====
package:
  name: mem_axi

sources:
  - logic/mem_bus_pkg.sv
  - logic/axi_pkg.sv
  - logic/mem_req_if.sv
  - logic/axi_arb.sv
  - logic/axi_master.sv
  - logic/mem_axi_top.sv
  - target: verif
    files:
      - verif/axi_mem_model.sv
      - verif/tb_mem_axi_top.sv

// ==== all.f ====
logic/mem_bus_pkg.sv
logic/axi_pkg.sv
logic/mem_req_if.sv
logic/axi_arb.sv
logic/axi_master.sv
logic/mem_axi_top.sv
verif/axi_mem_model.sv
verif/tb_mem_axi_top.sv

// ==== logic/axi_arb.sv ====
`default_nettype none

module axi_arb #(
  parameter int ADDR_WIDTH = mem_bus_pkg::ADDR_WIDTH_DEF,
  parameter int DATA_WIDTH = mem_bus_pkg::DATA_WIDTH_DEF
) (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  mem_req_if.responder          if_rd,    // fetch read
  mem_req_if.responder          mem_rd,   // data read
  mem_req_if.responder          mem_wr,   // data write, owns the write path
  mem_req_if.requester          ar_rd,
  mem_req_if.requester          ar_wr,
  output mem_bus_pkg::req_src_e grant_o
);

  mem_bus_pkg::req_src_e  grant_q;
  mem_bus_pkg::req_src_e  sel;
  logic                   sel_valid;
  logic [ADDR_WIDTH-1:0]  sel_addr;
  logic [7:0]             sel_mask;
  mem_bus_pkg::req_size_e sel_size;

  // a held grant wins, otherwise fetch before data
  always_comb begin
    if (grant_q != mem_bus_pkg::SRC_NONE) sel = grant_q;
    else if (if_rd.valid)                 sel = mem_bus_pkg::SRC_FETCH;
    else if (mem_rd.valid)                sel = mem_bus_pkg::SRC_DATA;
    else                                  sel = mem_bus_pkg::SRC_NONE;
  end

  always_comb begin
    sel_valid = 1'b0;
    sel_addr  = {ADDR_WIDTH{1'b0}};
    sel_mask  = 8'h00;
    sel_size  = mem_bus_pkg::SIZE_D;
    case (sel)
      mem_bus_pkg::SRC_FETCH: begin
        sel_valid = if_rd.valid;
        sel_addr  = if_rd.addr;
        sel_mask  = if_rd.mask;
        sel_size  = if_rd.size;
      end
      mem_bus_pkg::SRC_DATA: begin
        sel_valid = mem_rd.valid;
        sel_addr  = mem_rd.addr;
        sel_mask  = mem_rd.mask;
        sel_size  = mem_rd.size;
      end
      default: ;
    endcase
  end

  assign ar_rd.valid = sel_valid;
  assign ar_rd.addr  = sel_addr;
  assign ar_rd.mask  = sel_mask;
  assign ar_rd.size  = sel_size;
  assign ar_rd.wdata = {DATA_WIDTH{1'b0}};  // reads carry no data

  // master leaves idle in the same cycle it first sees valid
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      grant_q <= mem_bus_pkg::SRC_NONE;
    end else if (grant_q == mem_bus_pkg::SRC_NONE) begin
      if (sel_valid) grant_q <= sel;
    end else if (ar_rd.ready) begin
      grant_q <= mem_bus_pkg::SRC_NONE;  // released on the response pulse
    end
  end

  assign grant_o = grant_q;

  // response only to the owner
  assign if_rd.ready  = (grant_q == mem_bus_pkg::SRC_FETCH) & ar_rd.ready;
  assign if_rd.err    = (grant_q == mem_bus_pkg::SRC_FETCH) & ar_rd.err;
  assign if_rd.rdata  = (grant_q == mem_bus_pkg::SRC_FETCH) ? ar_rd.rdata : {DATA_WIDTH{1'b0}};
  assign mem_rd.ready = (grant_q == mem_bus_pkg::SRC_DATA) & ar_rd.ready;
  assign mem_rd.err   = (grant_q == mem_bus_pkg::SRC_DATA) & ar_rd.err;
  assign mem_rd.rdata = (grant_q == mem_bus_pkg::SRC_DATA) ? ar_rd.rdata : {DATA_WIDTH{1'b0}};

  // write path straight through
  assign ar_wr.valid  = mem_wr.valid;
  assign ar_wr.addr   = mem_wr.addr;
  assign ar_wr.mask   = mem_wr.mask;
  assign ar_wr.size   = mem_wr.size;
  assign ar_wr.wdata  = mem_wr.wdata;
  assign mem_wr.ready = ar_wr.ready;
  assign mem_wr.err   = ar_wr.err;
  assign mem_wr.rdata = ar_wr.rdata;

  // the owner keeps its request up until the answer
  a_grant_locked: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (grant_q != mem_bus_pkg::SRC_NONE && !ar_rd.ready) |-> ar_rd.valid);

  // the master must answer only a pending request of the owner
  a_ready_owner: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (if_rd.ready |-> if_rd.valid) and (mem_rd.ready |-> mem_rd.valid));

endmodule

`default_nettype wire

// ==== logic/axi_master.sv ====
`default_nettype none

module axi_master #(
  parameter int ADDR_WIDTH = mem_bus_pkg::ADDR_WIDTH_DEF,
  parameter int DATA_WIDTH = mem_bus_pkg::DATA_WIDTH_DEF
) (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  mem_req_if.responder          rd,
  mem_req_if.responder          wr,
  input  mem_bus_pkg::req_src_e grant_i,
  // ar
  output logic                  m_axi_arvalid_o,
  input  logic                  m_axi_arready_i,
  output logic [ADDR_WIDTH-1:0] m_axi_araddr_o,
  output logic [3:0]            m_axi_arid_o,
  output logic [2:0]            m_axi_arsize_o,
  output logic [7:0]            m_axi_arlen_o,
  output logic [1:0]            m_axi_arburst_o,
  // r
  input  logic                  m_axi_rvalid_i,
  output logic                  m_axi_rready_o,
  input  logic [DATA_WIDTH-1:0] m_axi_rdata_i,
  input  logic [1:0]            m_axi_rresp_i,
  input  logic                  m_axi_rlast_i,
  // aw
  output logic                  m_axi_awvalid_o,
  input  logic                  m_axi_awready_i,
  output logic [ADDR_WIDTH-1:0] m_axi_awaddr_o,
  output logic [3:0]            m_axi_awid_o,
  output logic [2:0]            m_axi_awsize_o,
  output logic [7:0]            m_axi_awlen_o,
  output logic [1:0]            m_axi_awburst_o,
  // w
  output logic                  m_axi_wvalid_o,
  input  logic                  m_axi_wready_i,
  output logic [DATA_WIDTH-1:0] m_axi_wdata_o,
  output logic [7:0]            m_axi_wstrb_o,
  output logic                  m_axi_wlast_o,
  // b
  input  logic                  m_axi_bvalid_i,
  output logic                  m_axi_bready_o,
  input  logic [1:0]            m_axi_bresp_i
);

  typedef enum logic [1:0] {RD_IDLE, RD_ADDR, RD_DATA} rd_state_e;
  typedef enum logic [1:0] {WR_IDLE, WR_REQ, WR_RESP} wr_state_e;

  rd_state_e             rd_state_q;
  wr_state_e             wr_state_q;
  logic                  rd_ready_q, wr_ready_q;
  logic [DATA_WIDTH-1:0] rd_data_q;
  logic                  rd_err_q, wr_err_q;
  logic                  aw_done_q, w_done_q;
  logic                  aw_ok, w_ok;

  function automatic logic [2:0] size_to_axsize(input mem_bus_pkg::req_size_e sz);
    case (sz)
      mem_bus_pkg::SIZE_B: return axi_pkg::AXSIZE_1B;
      mem_bus_pkg::SIZE_H: return axi_pkg::AXSIZE_2B;
      mem_bus_pkg::SIZE_W: return axi_pkg::AXSIZE_4B;
      default:             return axi_pkg::AXSIZE_8B;
    endcase
  endfunction

  // read side
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rd_state_q <= RD_IDLE;
      rd_ready_q <= 1'b0;
    end else begin
      rd_ready_q <= 1'b0;
      case (rd_state_q)
        RD_IDLE: if (rd.valid && !rd_ready_q) rd_state_q <= RD_ADDR;  // skip the answered one
        RD_ADDR: if (m_axi_arready_i) rd_state_q <= RD_DATA;
        RD_DATA: begin
          if (m_axi_rvalid_i) begin
            rd_state_q <= RD_IDLE;
            rd_ready_q <= 1'b1;
          end
        end
        default: rd_state_q <= RD_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (rd_state_q == RD_DATA && m_axi_rvalid_i) begin
      rd_data_q <= m_axi_rdata_i;
      // a single beat must also be the last one
      rd_err_q  <= (m_axi_rresp_i != axi_pkg::RESP_OKAY) | ~m_axi_rlast_i;
    end
  end

  assign m_axi_arvalid_o = (rd_state_q == RD_ADDR);
  assign m_axi_araddr_o  = rd.addr;
  assign m_axi_arid_o    = (grant_i == mem_bus_pkg::SRC_DATA) ? axi_pkg::ID_DATA
                                                              : axi_pkg::ID_FETCH;
  assign m_axi_arsize_o  = size_to_axsize(rd.size);
  assign m_axi_arlen_o   = 8'd0;
  assign m_axi_arburst_o = axi_pkg::BURST_INCR;
  assign m_axi_rready_o  = (rd_state_q == RD_DATA);

  assign rd.ready = rd_ready_q;
  assign rd.rdata = rd_data_q;
  assign rd.err   = rd_err_q;

  // write side, aw and w raised together and each dropped on its own
  assign aw_ok = aw_done_q | m_axi_awready_i;
  assign w_ok  = w_done_q | m_axi_wready_i;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      wr_state_q <= WR_IDLE;
      wr_ready_q <= 1'b0;
      aw_done_q  <= 1'b0;
      w_done_q   <= 1'b0;
    end else begin
      wr_ready_q <= 1'b0;
      case (wr_state_q)
        WR_IDLE: if (wr.valid && !wr_ready_q) wr_state_q <= WR_REQ;
        WR_REQ: begin
          if (aw_ok && w_ok) begin
            wr_state_q <= WR_RESP;
            aw_done_q  <= 1'b0;
            w_done_q   <= 1'b0;
          end else begin
            aw_done_q <= aw_ok;
            w_done_q  <= w_ok;
          end
        end
        WR_RESP: begin
          if (m_axi_bvalid_i) begin
            wr_state_q <= WR_IDLE;
            wr_ready_q <= 1'b1;
          end
        end
        default: wr_state_q <= WR_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (wr_state_q == WR_RESP && m_axi_bvalid_i) wr_err_q <= (m_axi_bresp_i != axi_pkg::RESP_OKAY);
  end

  assign m_axi_awvalid_o = (wr_state_q == WR_REQ) & ~aw_done_q;
  assign m_axi_awaddr_o  = wr.addr;
  assign m_axi_awid_o    = axi_pkg::ID_DATA;
  assign m_axi_awsize_o  = size_to_axsize(wr.size);
  assign m_axi_awlen_o   = 8'd0;
  assign m_axi_awburst_o = axi_pkg::BURST_INCR;
  assign m_axi_wvalid_o  = (wr_state_q == WR_REQ) & ~w_done_q;
  assign m_axi_wdata_o   = wr.wdata;
  assign m_axi_wstrb_o   = wr.mask;
  assign m_axi_wlast_o   = 1'b1;
  assign m_axi_bready_o  = (wr_state_q == WR_RESP);

  assign wr.ready = wr_ready_q;
  assign wr.rdata = {DATA_WIDTH{1'b0}};
  assign wr.err   = wr_err_q;

  // valid and payload held until the slave takes them
  a_ar_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    m_axi_arvalid_o && !m_axi_arready_i |=> m_axi_arvalid_o && $stable(m_axi_araddr_o)
      && $stable(m_axi_arid_o) && $stable(m_axi_arsize_o));

  a_aw_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    m_axi_awvalid_o && !m_axi_awready_i |=> m_axi_awvalid_o && $stable(m_axi_awaddr_o)
      && $stable(m_axi_awsize_o));

  // requester and arbiter keep the request still until ready
  a_rd_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    rd_state_q != RD_IDLE |=> $stable(rd.addr) && $stable(rd.size) && $stable(grant_i));

  a_wr_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    wr_state_q != WR_IDLE |=> $stable(wr.addr) && $stable(wr.wdata) && $stable(wr.mask));

endmodule

`default_nettype wire

// ==== logic/axi_pkg.sv ====
`default_nettype none

package axi_pkg;

  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_EXOKAY = 2'b01,
    RESP_SLVERR = 2'b10,
    RESP_DECERR = 2'b11
  } resp_e;

  localparam logic [1:0] BURST_INCR = 2'b01;  // only single beats go out anyway

  // axsize, bytes per beat as log2
  localparam logic [2:0] AXSIZE_1B = 3'b000;
  localparam logic [2:0] AXSIZE_2B = 3'b001;
  localparam logic [2:0] AXSIZE_4B = 3'b010;
  localparam logic [2:0] AXSIZE_8B = 3'b011;

  // transaction ids per requester
  localparam logic [3:0] ID_FETCH = 4'd0;
  localparam logic [3:0] ID_DATA  = 4'd1;

endpackage

`default_nettype wire

// ==== logic/mem_axi_top.sv ====
`default_nettype none

module mem_axi_top #(
  parameter int ADDR_WIDTH = mem_bus_pkg::ADDR_WIDTH_DEF,
  parameter int DATA_WIDTH = mem_bus_pkg::DATA_WIDTH_DEF
) (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  // fetch port
  input  logic [ADDR_WIDTH-1:0]  if_addr_i,
  input  logic                   if_valid_i,
  input  logic [7:0]             if_mask_i,
  input  mem_bus_pkg::req_size_e if_size_i,
  output logic [DATA_WIDTH-1:0]  if_rdata_o,
  output logic                   if_ready_o,
  output logic                   if_err_o,
  // data read port
  input  logic [ADDR_WIDTH-1:0]  mem_raddr_i,
  input  logic                   mem_rvalid_i,
  input  logic [7:0]             mem_rmask_i,
  input  mem_bus_pkg::req_size_e mem_rsize_i,
  output logic [DATA_WIDTH-1:0]  mem_rdata_o,
  output logic                   mem_rready_o,
  output logic                   mem_rerr_o,
  // data write port
  input  logic [ADDR_WIDTH-1:0]  mem_waddr_i,
  input  logic                   mem_wvalid_i,
  input  logic [7:0]             mem_wmask_i,
  input  mem_bus_pkg::req_size_e mem_wsize_i,
  input  logic [DATA_WIDTH-1:0]  mem_wdata_i,
  output logic                   mem_wready_o,
  output logic                   mem_werr_o,
  // axi4 master
  output logic                   m_axi_arvalid_o,
  input  logic                   m_axi_arready_i,
  output logic [ADDR_WIDTH-1:0]  m_axi_araddr_o,
  output logic [3:0]             m_axi_arid_o,
  output logic [2:0]             m_axi_arsize_o,
  output logic [7:0]             m_axi_arlen_o,
  output logic [1:0]             m_axi_arburst_o,
  input  logic                   m_axi_rvalid_i,
  output logic                   m_axi_rready_o,
  input  logic [DATA_WIDTH-1:0]  m_axi_rdata_i,
  input  logic [1:0]             m_axi_rresp_i,
  input  logic                   m_axi_rlast_i,
  output logic                   m_axi_awvalid_o,
  input  logic                   m_axi_awready_i,
  output logic [ADDR_WIDTH-1:0]  m_axi_awaddr_o,
  output logic [3:0]             m_axi_awid_o,
  output logic [2:0]             m_axi_awsize_o,
  output logic [7:0]             m_axi_awlen_o,
  output logic [1:0]             m_axi_awburst_o,
  output logic                   m_axi_wvalid_o,
  input  logic                   m_axi_wready_i,
  output logic [DATA_WIDTH-1:0]  m_axi_wdata_o,
  output logic [7:0]             m_axi_wstrb_o,
  output logic                   m_axi_wlast_o,
  input  logic                   m_axi_bvalid_i,
  output logic                   m_axi_bready_o,
  input  logic [1:0]             m_axi_bresp_i
);

  mem_bus_pkg::req_src_e grant;

  mem_req_if #(.ADDR_WIDTH(ADDR_WIDTH), .DATA_WIDTH(DATA_WIDTH)) if_rd ();
  mem_req_if #(.ADDR_WIDTH(ADDR_WIDTH), .DATA_WIDTH(DATA_WIDTH)) mem_rd ();
  mem_req_if #(.ADDR_WIDTH(ADDR_WIDTH), .DATA_WIDTH(DATA_WIDTH)) mem_wr ();
  mem_req_if #(.ADDR_WIDTH(ADDR_WIDTH), .DATA_WIDTH(DATA_WIDTH)) ar_rd ();
  mem_req_if #(.ADDR_WIDTH(ADDR_WIDTH), .DATA_WIDTH(DATA_WIDTH)) ar_wr ();

  // fetch
  assign if_rd.addr  = if_addr_i;
  assign if_rd.valid = if_valid_i;
  assign if_rd.mask  = if_mask_i;
  assign if_rd.size  = if_size_i;
  assign if_rd.wdata = {DATA_WIDTH{1'b0}};
  assign if_rdata_o  = if_rd.rdata;
  assign if_ready_o  = if_rd.ready;
  assign if_err_o    = if_rd.err;

  // data read
  assign mem_rd.addr  = mem_raddr_i;
  assign mem_rd.valid = mem_rvalid_i;
  assign mem_rd.mask  = mem_rmask_i;
  assign mem_rd.size  = mem_rsize_i;
  assign mem_rd.wdata = {DATA_WIDTH{1'b0}};
  assign mem_rdata_o  = mem_rd.rdata;
  assign mem_rready_o = mem_rd.ready;
  assign mem_rerr_o   = mem_rd.err;

  // data write, rdata of this channel stays inside
  assign mem_wr.addr  = mem_waddr_i;
  assign mem_wr.valid = mem_wvalid_i;
  assign mem_wr.mask  = mem_wmask_i;
  assign mem_wr.size  = mem_wsize_i;
  assign mem_wr.wdata = mem_wdata_i;
  assign mem_wready_o = mem_wr.ready;
  assign mem_werr_o   = mem_wr.err;

  axi_arb #(
    .ADDR_WIDTH (ADDR_WIDTH),
    .DATA_WIDTH (DATA_WIDTH)
  ) u_arb (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .if_rd   (if_rd.responder),
    .mem_rd  (mem_rd.responder),
    .mem_wr  (mem_wr.responder),
    .ar_rd   (ar_rd.requester),
    .ar_wr   (ar_wr.requester),
    .grant_o (grant)
  );

  axi_master #(
    .ADDR_WIDTH (ADDR_WIDTH),
    .DATA_WIDTH (DATA_WIDTH)
  ) u_master (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .rd              (ar_rd.responder),
    .wr              (ar_wr.responder),
    .grant_i         (grant),
    .m_axi_arvalid_o (m_axi_arvalid_o),
    .m_axi_arready_i (m_axi_arready_i),
    .m_axi_araddr_o  (m_axi_araddr_o),
    .m_axi_arid_o    (m_axi_arid_o),
    .m_axi_arsize_o  (m_axi_arsize_o),
    .m_axi_arlen_o   (m_axi_arlen_o),
    .m_axi_arburst_o (m_axi_arburst_o),
    .m_axi_rvalid_i  (m_axi_rvalid_i),
    .m_axi_rready_o  (m_axi_rready_o),
    .m_axi_rdata_i   (m_axi_rdata_i),
    .m_axi_rresp_i   (m_axi_rresp_i),
    .m_axi_rlast_i   (m_axi_rlast_i),
    .m_axi_awvalid_o (m_axi_awvalid_o),
    .m_axi_awready_i (m_axi_awready_i),
    .m_axi_awaddr_o  (m_axi_awaddr_o),
    .m_axi_awid_o    (m_axi_awid_o),
    .m_axi_awsize_o  (m_axi_awsize_o),
    .m_axi_awlen_o   (m_axi_awlen_o),
    .m_axi_awburst_o (m_axi_awburst_o),
    .m_axi_wvalid_o  (m_axi_wvalid_o),
    .m_axi_wready_i  (m_axi_wready_i),
    .m_axi_wdata_o   (m_axi_wdata_o),
    .m_axi_wstrb_o   (m_axi_wstrb_o),
    .m_axi_wlast_o   (m_axi_wlast_o),
    .m_axi_bvalid_i  (m_axi_bvalid_i),
    .m_axi_bready_o  (m_axi_bready_o),
    .m_axi_bresp_i   (m_axi_bresp_i)
  );

endmodule

`default_nettype wire

// ==== logic/mem_bus_pkg.sv ====
`default_nettype none

// requester side of the memory bus

package mem_bus_pkg;

  // defaults only, the top sets the real widths
  localparam int ADDR_WIDTH_DEF = 32;
  localparam int DATA_WIDTH_DEF = 64;  // xlen of the core

  // access size as the core encodes it
  typedef enum logic [2:0] {
    SIZE_B = 3'd0,  // byte
    SIZE_H = 3'd1,  // half word
    SIZE_W = 3'd2,  // word
    SIZE_D = 3'd3   // double word
  } req_size_e;

  // owner of the read path
  typedef enum logic [1:0] {
    SRC_NONE  = 2'd0,
    SRC_FETCH = 2'd1,
    SRC_DATA  = 2'd2
  } req_src_e;

endpackage

`default_nettype wire

// ==== logic/mem_req_if.sv ====
`default_nettype none

// one requester channel, valid held until a single-cycle ready
interface mem_req_if #(
  parameter int ADDR_WIDTH = mem_bus_pkg::ADDR_WIDTH_DEF,
  parameter int DATA_WIDTH = mem_bus_pkg::DATA_WIDTH_DEF
);

  logic [ADDR_WIDTH-1:0]  addr;
  logic                   valid;
  logic [7:0]             mask;   // byte enables
  mem_bus_pkg::req_size_e size;
  logic [DATA_WIDTH-1:0]  wdata;

  logic [DATA_WIDTH-1:0]  rdata;  // valid with ready
  logic                   ready;  // one cycle pulse
  logic                   err;    // response was not okay

  modport requester (
    output addr, valid, mask, size, wdata,
    input  rdata, ready, err
  );

  modport responder (
    input  addr, valid, mask, size, wdata,
    output rdata, ready, err
  );

endinterface

`default_nettype wire

// ==== verif/axi_mem_model.sv ====
`default_nettype none

// single beat axi4 slave with 256 doublewords, slverr from 0x800 up
module axi_mem_model (
  input  logic        clk_i,
  input  logic        rst_n_i,
  input  logic        arvalid_i,
  output logic        arready_o,
  input  logic [31:0] araddr_i,
  output logic        rvalid_o,
  input  logic        rready_i,
  output logic [63:0] rdata_o,
  output logic [1:0]  rresp_o,
  output logic        rlast_o,
  input  logic        awvalid_i,
  output logic        awready_o,
  input  logic [31:0] awaddr_i,
  input  logic        wvalid_i,
  output logic        wready_o,
  input  logic [63:0] wdata_i,
  input  logic [7:0]  wstrb_i,
  output logic        bvalid_o,
  input  logic        bready_i,
  output logic [1:0]  bresp_o
);

  logic [63:0] mem [0:255];
  integer      seed = 32'hf1ab_89ca;
  logic [1:0]  ar_wait, r_wait, aw_wait, w_wait, b_wait;
  logic        r_pend, aw_got, w_got;
  logic [31:0] awaddr_q;
  logic [63:0] wdata_q;
  logic [7:0]  wstrb_q;

  assign rlast_o = 1'b1;

  function logic [1:0] draw_delay();
    integer r;
    r = $random(seed);
    return r[1:0];  // 0 to 3 cycles
  endfunction

  function automatic logic [63:0] apply_strobe(input logic [63:0] old_w,
                                               input logic [63:0] new_w,
                                               input logic [7:0]  strb);
    logic [63:0] res;
    res = old_w;
    for (int b = 0; b < 8; b++) begin
      if (strb[b]) res[8*b +: 8] = new_w[8*b +: 8];
    end
    return res;
  endfunction

  always @(posedge clk_i) begin
    if (!rst_n_i) begin
      arready_o <= 1'b0;
      rvalid_o  <= 1'b0;
      awready_o <= 1'b0;
      wready_o  <= 1'b0;
      bvalid_o  <= 1'b0;
      r_pend    <= 1'b0;
      aw_got    <= 1'b0;
      w_got     <= 1'b0;
      ar_wait   <= 2'd0;
      aw_wait   <= 2'd0;
      w_wait    <= 2'd0;
    end else begin
      arready_o <= 1'b0;
      awready_o <= 1'b0;
      wready_o  <= 1'b0;

      // read address, data picked at acceptance
      if (arvalid_i && arready_o) begin
        r_pend  <= 1'b1;
        r_wait  <= draw_delay();
        rresp_o <= (araddr_i >= 32'h800) ? axi_pkg::RESP_SLVERR : axi_pkg::RESP_OKAY;
        rdata_o <= (araddr_i >= 32'h800) ? 64'h0 : mem[araddr_i[10:3]];
      end else if (arvalid_i && !r_pend && !rvalid_o) begin
        if (ar_wait == 2'd0) begin
          arready_o <= 1'b1;
          ar_wait   <= draw_delay();
        end else ar_wait <= ar_wait - 2'd1;
      end

      if (r_pend && !rvalid_o) begin
        if (r_wait == 2'd0) begin
          rvalid_o <= 1'b1;
          r_pend   <= 1'b0;
        end else r_wait <= r_wait - 2'd1;
      end else if (rvalid_o && rready_i) rvalid_o <= 1'b0;

      // aw and w each on their own delay
      if (awvalid_i && awready_o) begin
        aw_got   <= 1'b1;
        awaddr_q <= awaddr_i;
      end else if (awvalid_i && !aw_got) begin
        if (aw_wait == 2'd0) begin
          awready_o <= 1'b1;
          aw_wait   <= draw_delay();
        end else aw_wait <= aw_wait - 2'd1;
      end

      if (wvalid_i && wready_o) begin
        w_got   <= 1'b1;
        wdata_q <= wdata_i;
        wstrb_q <= wstrb_i;
      end else if (wvalid_i && !w_got) begin
        if (w_wait == 2'd0) begin
          wready_o <= 1'b1;
          w_wait   <= draw_delay();
        end else w_wait <= w_wait - 2'd1;
      end

      if (aw_got && w_got) begin
        if (b_wait == 2'd0) begin
          bvalid_o <= 1'b1;
          aw_got   <= 1'b0;
          w_got    <= 1'b0;
          b_wait   <= draw_delay();
          if (awaddr_q >= 32'h800) begin
            bresp_o <= axi_pkg::RESP_SLVERR;
          end else begin
            bresp_o <= axi_pkg::RESP_OKAY;
            mem[awaddr_q[10:3]] <= apply_strobe(mem[awaddr_q[10:3]], wdata_q, wstrb_q);
          end
        end else b_wait <= b_wait - 2'd1;
      end else if (bvalid_o && bready_i) bvalid_o <= 1'b0;
    end
  end

  initial b_wait = 2'd0;

endmodule

`default_nettype wire

// ==== verif/tb_mem_axi_top.sv ====
`default_nettype none

module tb_mem_axi_top;

  localparam int TIMEOUT = 100;  // cycles per wait

  logic clk = 1'b0;
  logic rst_n = 1'b0;
  int   cycle = 0;
  integer seed = 32'hf1ab_89ca;

  logic [31:0] if_addr, mem_raddr, mem_waddr;
  logic        if_valid, mem_rvalid, mem_wvalid;
  logic [7:0]  if_mask, mem_rmask, mem_wmask;
  mem_bus_pkg::req_size_e if_size, mem_rsize, mem_wsize;
  logic [63:0] mem_wdata;
  wire  [63:0] if_rdata_o, mem_rdata_o;
  wire         if_ready_o, if_err_o, mem_rready_o, mem_rerr_o, mem_wready_o, mem_werr_o;

  // axi between dut and memory model
  wire        arvalid, arready, rvalid, rready, rlast;
  wire        awvalid, awready, wvalid, wready, wlast, bvalid, bready;
  wire [31:0] araddr, awaddr;
  wire [63:0] rdata, wdata;
  wire [3:0]  arid, awid;
  wire [2:0]  arsize, awsize;
  wire [7:0]  wstrb, arlen, awlen;
  wire [1:0]  rresp, bresp, arburst, awburst;

  logic [63:0] shadow [0:255];

  always #5 clk = ~clk;
  always @(posedge clk) cycle <= cycle + 1;

  mem_axi_top #(.ADDR_WIDTH(32), .DATA_WIDTH(64)) uut (
    .clk_i (clk), .rst_n_i (rst_n),
    .if_addr_i (if_addr), .if_valid_i (if_valid), .if_mask_i (if_mask),
    .if_size_i (if_size), .if_rdata_o (if_rdata_o), .if_ready_o (if_ready_o),
    .if_err_o (if_err_o),
    .mem_raddr_i (mem_raddr), .mem_rvalid_i (mem_rvalid), .mem_rmask_i (mem_rmask),
    .mem_rsize_i (mem_rsize), .mem_rdata_o (mem_rdata_o), .mem_rready_o (mem_rready_o),
    .mem_rerr_o (mem_rerr_o),
    .mem_waddr_i (mem_waddr), .mem_wvalid_i (mem_wvalid), .mem_wmask_i (mem_wmask),
    .mem_wsize_i (mem_wsize), .mem_wdata_i (mem_wdata), .mem_wready_o (mem_wready_o),
    .mem_werr_o (mem_werr_o),
    .m_axi_arvalid_o (arvalid), .m_axi_arready_i (arready), .m_axi_araddr_o (araddr),
    .m_axi_arid_o (arid), .m_axi_arsize_o (arsize), .m_axi_arlen_o (arlen),
    .m_axi_arburst_o (arburst),
    .m_axi_rvalid_i (rvalid), .m_axi_rready_o (rready), .m_axi_rdata_i (rdata),
    .m_axi_rresp_i (rresp), .m_axi_rlast_i (rlast),
    .m_axi_awvalid_o (awvalid), .m_axi_awready_i (awready), .m_axi_awaddr_o (awaddr),
    .m_axi_awid_o (awid), .m_axi_awsize_o (awsize), .m_axi_awlen_o (awlen),
    .m_axi_awburst_o (awburst),
    .m_axi_wvalid_o (wvalid), .m_axi_wready_i (wready), .m_axi_wdata_o (wdata),
    .m_axi_wstrb_o (wstrb), .m_axi_wlast_o (wlast),
    .m_axi_bvalid_i (bvalid), .m_axi_bready_o (bready), .m_axi_bresp_i (bresp)
  );

  axi_mem_model mem_model (
    .clk_i (clk), .rst_n_i (rst_n),
    .arvalid_i (arvalid), .arready_o (arready), .araddr_i (araddr),
    .rvalid_o (rvalid), .rready_i (rready), .rdata_o (rdata), .rresp_o (rresp),
    .rlast_o (rlast),
    .awvalid_i (awvalid), .awready_o (awready), .awaddr_i (awaddr),
    .wvalid_i (wvalid), .wready_o (wready), .wdata_i (wdata), .wstrb_i (wstrb),
    .bvalid_o (bvalid), .bready_i (bready), .bresp_o (bresp)
  );

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("*** FAILED ***");
    $fatal(1);
  endtask

  // every doubleword gets its own value from its byte address
  function automatic logic [63:0] fill_word(input int idx);
    logic [31:0] a;
    a = idx * 8;
    return {a ^ 32'hc3c3_0000, ~a};
  endfunction

  // ready may only answer a request that is still pending
  always @(negedge clk) begin
    if (rst_n) begin
      assert (!(if_ready_o && !if_valid)) else report_failure("fetch ready with no request");
      assert (!(mem_rready_o && !mem_rvalid)) else report_failure("data ready with no read");
      assert (!(mem_wready_o && !mem_wvalid)) else report_failure("write ready with no write");
    end
  end

  // every axi transfer is a single INCR beat of eight bytes
  always @(negedge clk) begin
    if (rst_n && arvalid) begin
      check_value("m_axi_arid_o", {60'd0, arid}, (if_valid && araddr == if_addr) ?
                  {60'd0, axi_pkg::ID_FETCH} : {60'd0, axi_pkg::ID_DATA});
      check_value("m_axi_arsize_o", {61'd0, arsize}, 64'd3);
      check_value("m_axi_arlen_o", {56'd0, arlen}, 64'd0);
      check_value("m_axi_arburst_o", {62'd0, arburst}, 64'd1);
    end
    if (rst_n && awvalid) begin
      check_value("m_axi_awid_o", {60'd0, awid}, {60'd0, axi_pkg::ID_DATA});
      check_value("m_axi_awsize_o", {61'd0, awsize}, 64'd3);
      check_value("m_axi_awlen_o", {56'd0, awlen}, 64'd0);
      check_value("m_axi_awburst_o", {62'd0, awburst}, 64'd1);
    end
    if (rst_n && wvalid) check_value("m_axi_wlast_o", {63'd0, wlast}, 64'd1);
  end

  task automatic read_port(input bit fetch, input logic [31:0] addr, output logic [63:0] data,
                           output logic err, output int done_cyc);
    int t;
    @(posedge clk);
    #1;
    if (fetch) begin
      if_addr  = addr;
      if_valid = 1'b1;
    end else begin
      mem_raddr  = addr;
      mem_rvalid = 1'b1;
    end
    t = 0;
    do begin
      @(negedge clk);
      t++;
      if (t > TIMEOUT) report_failure("timeout waiting for read ready");
    end while (!(fetch ? if_ready_o : mem_rready_o));
    data     = fetch ? if_rdata_o : mem_rdata_o;
    err      = fetch ? if_err_o : mem_rerr_o;
    done_cyc = cycle;
    @(posedge clk);
    #1;
    if (fetch) if_valid = 1'b0;
    else mem_rvalid = 1'b0;
  endtask

  task automatic write_port(input logic [31:0] addr, input logic [63:0] data,
                            input logic [7:0] mask, output logic err);
    int t;
    @(posedge clk);
    #1;
    mem_waddr  = addr;
    mem_wdata  = data;
    mem_wmask  = mask;
    mem_wvalid = 1'b1;
    t = 0;
    do begin
      @(negedge clk);
      t++;
      if (t > TIMEOUT) report_failure("timeout waiting for write ready");
    end while (!mem_wready_o);
    err = mem_werr_o;
    @(posedge clk);
    #1 mem_wvalid = 1'b0;
    if (addr < 32'h800) begin
      for (int b = 0; b < 8; b++) begin
        if (mask[b]) shadow[addr[10:3]][8*b +: 8] = data[8*b +: 8];
      end
    end
  endtask

  task automatic check_value(input string name, input logic [63:0] got, input logic [63:0] exp);
    assert (got === exp) else report_failure($sformatf("ERR %s got %h expected %h", name, got, exp));
  endtask

  task automatic check_read(input bit fetch, input logic [31:0] addr);
    logic [63:0] data;
    logic        err;
    int          cyc;
    read_port(fetch, addr, data, err, cyc);
    check_value(fetch ? "if_rdata_o" : "mem_rdata_o", data, shadow[addr[10:3]]);
    check_value(fetch ? "if_err_o" : "mem_rerr_o", {63'd0, err}, 64'd0);
  endtask

  task automatic fetch_reads();
    check_read(1'b1, 32'h000);
    check_read(1'b1, 32'h008);
    check_read(1'b1, 32'h3a0);
    check_read(1'b1, 32'h7f8);
  endtask

  task automatic write_then_read();
    logic err;
    write_port(32'h100, 64'h0123_4567_89ab_cdef, 8'hff, err);
    check_value("mem_werr_o", {63'd0, err}, 64'd0);
    check_read(1'b0, 32'h100);
  endtask

  task automatic masked_write();
    logic        err;
    logic [63:0] data;
    data = {$random(seed), $random(seed)};
    write_port(32'h108, data, 8'h5a, err);
    check_value("mem_werr_o", {63'd0, err}, 64'd0);
    check_read(1'b0, 32'h108);
  endtask

  task automatic simultaneous_reads();
    logic [63:0] f_data, d_data;
    logic        f_err, d_err;
    int          f_cyc, d_cyc;
    fork
      read_port(1'b1, 32'h040, f_data, f_err, f_cyc);
      read_port(1'b0, 32'h0c8, d_data, d_err, d_cyc);
    join
    check_value("if_rdata_o", f_data, shadow[8'h08]);
    check_value("mem_rdata_o", d_data, shadow[8'h19]);
    check_value("if_err_o", {63'd0, f_err}, 64'd0);
    check_value("mem_rerr_o", {63'd0, d_err}, 64'd0);
    assert (f_cyc < d_cyc) else report_failure("data read finished before the fetch read");
  endtask

  task automatic write_during_fetch();
    logic [63:0] f_data;
    logic        f_err, w_err;
    int          f_cyc;
    fork
      write_port(32'h200, 64'hfeed_face_cafe_beef, 8'hff, w_err);
      read_port(1'b1, 32'h300, f_data, f_err, f_cyc);
    join
    check_value("if_rdata_o", f_data, shadow[8'h60]);
    check_value("if_err_o", {63'd0, f_err}, 64'd0);
    check_value("mem_werr_o", {63'd0, w_err}, 64'd0);
    check_read(1'b0, 32'h200);
  endtask

  task automatic error_responses();
    logic [63:0] data;
    logic        err;
    int          cyc;
    read_port(1'b0, 32'h800, data, err, cyc);
    check_value("mem_rerr_o", {63'd0, err}, 64'd1);
    read_port(1'b1, 32'h900, data, err, cyc);
    check_value("if_err_o", {63'd0, err}, 64'd1);
    write_port(32'h810, 64'h1111_2222_3333_4444, 8'hff, err);
    check_value("mem_werr_o", {63'd0, err}, 64'd1);
  endtask

  initial begin
    if_addr    = 32'h0;
    if_valid   = 1'b0;
    if_mask    = 8'hff;
    if_size    = mem_bus_pkg::SIZE_D;
    mem_raddr  = 32'h0;
    mem_rvalid = 1'b0;
    mem_rmask  = 8'hff;
    mem_rsize  = mem_bus_pkg::SIZE_D;
    mem_waddr  = 32'h0;
    mem_wvalid = 1'b0;
    mem_wmask  = 8'h00;
    mem_wsize  = mem_bus_pkg::SIZE_D;
    mem_wdata  = 64'h0;
    for (int i = 0; i < 256; i++) begin
      shadow[i]        = fill_word(i);
      mem_model.mem[i] = fill_word(i);
    end
    repeat (3) @(posedge clk);
    #1 rst_n = 1'b1;

    fetch_reads();
    write_then_read();
    masked_write();
    simultaneous_reads();
    write_during_fetch();
    error_responses();

    $display("*** PASSED ***");
    $finish;
  end

endmodule

`default_nettype wire
